// ==== verilog/exec_pkg.sv ====
// Execute pipeline shared types

package exec_pkg;

    // ------------------------------
    // Data widths
    // ------------------------------
    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [XLEN-1:0] pc_t;
    typedef logic [4:0]      reg_idx_t;

    // Memory access size as log2 of the byte count
    typedef logic [1:0] mem_size_t;
    typedef logic [7:0] byte_mask_t;

    localparam mem_size_t SIZE_B = 2'd0;
    localparam mem_size_t SIZE_H = 2'd1;
    localparam mem_size_t SIZE_W = 2'd2;
    localparam mem_size_t SIZE_D = 2'd3;

    // Data RAM word count
    localparam int DMEM_DEPTH_DEFAULT = 512;

    // ------------------------------
    // ALU operation and operand selects
    // ------------------------------
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC1_RS1,
        SRC1_PC,
        SRC1_ZERO
    } src1_sel_t;

    typedef enum logic [1:0] {
        SRC2_RS2,
        SRC2_IMM,
        SRC2_FOUR
    } src2_sel_t;

endpackage

// ==== verilog/pipe_if.sv ====
// Pipeline stage interfaces
`timescale 1ns/1ps

// Execute to memory stage record with valid/allowin handshake
interface es_to_ms_if;
    import exec_pkg::*;

    logic      valid;
    logic      allowin;
    reg_idx_t  rd;
    logic      rf_we;
    logic      mem_re;
    mem_size_t mem_size;
    logic      load_unsigned;
    xlen_t     result;
    pc_t       pc;

    modport master (
        output valid, rd, rf_we, mem_re, mem_size, load_unsigned, result, pc,
        input  allowin
    );

    modport slave (
        input  valid, rd, rf_we, mem_re, mem_size, load_unsigned, result, pc,
        output allowin
    );
endinterface

// Stage to data RAM with a double-word index as addr
interface dmem_if #(
    parameter int DEPTH = exec_pkg::DMEM_DEPTH_DEFAULT
);
    import exec_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic             en;
    byte_mask_t       we;
    logic [IDX_W-1:0] addr;
    xlen_t            wdata;
    xlen_t            rdata;

    modport master (output en, we, addr, wdata, input rdata);
    modport slave  (input en, we, addr, wdata, output rdata);
    // Load data consumer
    modport resp   (input rdata);
endinterface

// ==== verilog/alu.sv ====
// Integer ALU
`timescale 1ns/1ps

module alu (
    input  exec_pkg::alu_op_t op,
    input  logic              word,
    input  exec_pkg::xlen_t   src1,
    input  exec_pkg::xlen_t   src2,
    output exec_pkg::xlen_t   result
);
    import exec_pkg::*;

    logic [5:0]  shamt;
    logic [31:0] src1_lo;
    logic [31:0] srl_w;
    logic [31:0] sra_w;
    xlen_t       sum;
    xlen_t       diff;
    xlen_t       raw;

    // Word shifts only look at five bits of the amount
    assign shamt   = word ? {1'b0, src2[4:0]} : src2[5:0];
    assign src1_lo = src1[31:0];

    // 32-bit right shifts filled with zeros or bit 31
    assign srl_w = src1_lo >> shamt[4:0];
    assign sra_w = $signed(src1_lo) >>> shamt[4:0];

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    always_comb begin
        case (op)
            OP_ADD:  raw = sum;
            OP_SUB:  raw = diff;
            OP_SLT:  raw = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            OP_SLTU: raw = {{(XLEN-1){1'b0}}, src1 < src2};
            OP_AND:  raw = src1 & src2;
            OP_OR:   raw = src1 | src2;
            OP_XOR:  raw = src1 ^ src2;
            // Low half of a 64-bit left shift equals the word form
            OP_SLL:  raw = src1 << shamt;
            OP_SRL: begin
                if (word) begin
                    raw = {32'b0, srl_w};
                end else begin
                    raw = src1 >> shamt;
                end
            end
            OP_SRA: begin
                if (word) begin
                    raw = {32'b0, sra_w};
                end else begin
                    raw = $signed(src1) >>> shamt;
                end
            end
            default: raw = '0;
        endcase
    end

    // Word forms return bit 31 sign-extended
    assign result = word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

// ==== verilog/exu_stage.sv ====
// Execute stage
`timescale 1ns/1ps

module exu_stage #(
    parameter int DMEM_DEPTH = exec_pkg::DMEM_DEPTH_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_allowin,
    input  exec_pkg::alu_op_t    in_op,
    input  logic                 in_word,
    input  exec_pkg::src1_sel_t  in_src1_sel,
    input  exec_pkg::src2_sel_t  in_src2_sel,
    input  exec_pkg::xlen_t      in_rs1_value,
    input  exec_pkg::xlen_t      in_rs2_value,
    input  exec_pkg::xlen_t      in_imm,
    input  exec_pkg::pc_t        in_pc,
    input  exec_pkg::reg_idx_t   in_rd,
    input  logic                 in_rf_we,
    input  logic                 in_mem_re,
    input  logic                 in_mem_we,
    input  exec_pkg::mem_size_t  in_mem_size,
    input  logic                 in_load_unsigned,
    es_to_ms_if.master           out,
    dmem_if.master               dmem,
    output logic                 fwd_valid,
    output logic                 fwd_load,
    output exec_pkg::reg_idx_t   fwd_rd,
    output exec_pkg::xlen_t      fwd_data
);
    import exec_pkg::*;

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    logic       es_valid;
    alu_op_t    r_op;
    logic       r_word;
    src1_sel_t  r_src1_sel;
    src2_sel_t  r_src2_sel;
    xlen_t      r_rs1;
    xlen_t      r_rs2;
    xlen_t      r_imm;
    pc_t        r_pc;
    reg_idx_t   r_rd;
    logic       r_rf_we;
    logic       r_mem_re;
    logic       r_mem_we;
    mem_size_t  r_mem_size;
    logic       r_load_unsigned;

    xlen_t      alu_src1;
    xlen_t      alu_src2;
    xlen_t      alu_result;
    byte_mask_t size_mask;

    // ------------------------------
    // Stage register
    // ------------------------------
    assign in_allowin = !es_valid || out.allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            r_op            <= in_op;
            r_word          <= in_word;
            r_src1_sel      <= in_src1_sel;
            r_src2_sel      <= in_src2_sel;
            r_rs1           <= in_rs1_value;
            r_rs2           <= in_rs2_value;
            r_imm           <= in_imm;
            r_pc            <= in_pc;
            r_rd            <= in_rd;
            r_rf_we         <= in_rf_we;
            r_mem_re        <= in_mem_re;
            r_mem_we        <= in_mem_we;
            r_mem_size      <= in_mem_size;
            r_load_unsigned <= in_load_unsigned;
        end
    end

    // ------------------------------
    // Operands and ALU
    // ------------------------------
    always_comb begin
        case (r_src1_sel)
            SRC1_PC:   alu_src1 = r_pc;
            SRC1_ZERO: alu_src1 = '0;
            default:   alu_src1 = r_rs1;
        endcase
        case (r_src2_sel)
            SRC2_IMM:  alu_src2 = r_imm;
            SRC2_FOUR: alu_src2 = xlen_t'(4);
            default:   alu_src2 = r_rs2;
        endcase
    end

    alu alu_inst (
        .op     (r_op),
        .word   (r_word),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    // ------------------------------
    // Data RAM access
    // ------------------------------
    always_comb begin
        case (r_mem_size)
            SIZE_B:  size_mask = 8'h01;
            SIZE_H:  size_mask = 8'h03;
            SIZE_W:  size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // Touch the RAM only on the edge the record moves on
    assign dmem.en    = es_valid && (r_mem_re || r_mem_we) && out.allowin;
    assign dmem.addr  = alu_result[IDX_W+2:3];
    assign dmem.we    = (dmem.en && r_mem_we) ? byte_mask_t'(size_mask << alu_result[2:0]) : '0;
    assign dmem.wdata = r_rs2 << {alu_result[2:0], 3'b000};

    // Record to memory stage
    assign out.valid         = es_valid;
    assign out.rd            = r_rd;
    assign out.rf_we         = r_rf_we;
    assign out.mem_re        = r_mem_re;
    assign out.mem_size      = r_mem_size;
    assign out.load_unsigned = r_load_unsigned;
    assign out.result        = alu_result;
    assign out.pc            = r_pc;

    // Forwarding record without load data
    assign fwd_valid = es_valid && r_rf_we;
    assign fwd_load  = es_valid && r_mem_re;
    assign fwd_rd    = r_rd;
    assign fwd_data  = alu_result;

    // Stalled record holds until the memory stage takes it
    assert property (@(posedge clk) disable iff (reset)
        out.valid && !out.allowin |=> out.valid && $stable(out.result) && $stable(out.rd));

    // Store covers exactly the bytes of its size
    assert property (@(posedge clk) disable iff (reset)
        (dmem.we != '0) |-> r_mem_we && ($countones(dmem.we) == (1 << r_mem_size)));

endmodule

// ==== verilog/data_ram.sv ====
// Data RAM with byte enables
`timescale 1ns/1ps

module data_ram #(
    parameter int DEPTH = exec_pkg::DMEM_DEPTH_DEFAULT
) (
    input  logic  clk,
    dmem_if.slave bus
);
    import exec_pkg::*;

    xlen_t mem [DEPTH];

    // Read returns the word before any write on the same edge
    always_ff @(posedge clk) begin
        if (bus.en) begin
            bus.rdata <= mem[bus.addr];
            for (int b = 0; b < XLEN / 8; b++) begin
                if (bus.we[b]) begin
                    mem[bus.addr][b*8 +: 8] <= bus.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Execute stage index stays inside the array
    assert property (@(posedge clk) bus.en |-> bus.addr < DEPTH);

endmodule

// ==== verilog/mem_stage.sv ====
// Memory stage
`timescale 1ns/1ps

module mem_stage (
    input  logic                clk,
    input  logic                reset,
    es_to_ms_if.slave           in,
    dmem_if.resp                dmem,
    input  logic                wb_allowin,
    output logic                wb_valid,
    output exec_pkg::reg_idx_t  wb_rd,
    output logic                wb_rf_we,
    output exec_pkg::xlen_t     wb_data,
    output exec_pkg::pc_t       wb_pc
);
    import exec_pkg::*;

    logic      ms_valid;
    logic      ms_allowin;
    logic      load_fresh;
    reg_idx_t  r_rd;
    logic      r_rf_we;
    logic      r_mem_re;
    mem_size_t r_mem_size;
    logic      r_load_unsigned;
    xlen_t     r_result;
    pc_t       r_pc;
    xlen_t     rdata_hold;

    xlen_t     load_word;
    xlen_t     lane;
    xlen_t     load_value;

    // ------------------------------
    // Stage register
    // ------------------------------
    assign ms_allowin = !ms_valid || wb_allowin;
    assign in.allowin = ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid   <= 1'b0;
            load_fresh <= 1'b0;
        end else begin
            if (ms_allowin) begin
                ms_valid <= in.valid;
            end
            load_fresh <= in.valid && ms_allowin && in.mem_re;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && ms_allowin) begin
            r_rd            <= in.rd;
            r_rf_we         <= in.rf_we;
            r_mem_re        <= in.mem_re;
            r_mem_size      <= in.mem_size;
            r_load_unsigned <= in.load_unsigned;
            r_result        <= in.result;
            r_pc            <= in.pc;
        end
    end

    // RAM output lasts one cycle so a stalled load keeps a copy
    always_ff @(posedge clk) begin
        if (load_fresh) begin
            rdata_hold <= dmem.rdata;
        end
    end

    // ------------------------------
    // Load alignment
    // ------------------------------
    assign load_word = load_fresh ? dmem.rdata : rdata_hold;
    assign lane      = load_word >> {r_result[2:0], 3'b000};

    always_comb begin
        case (r_mem_size)
            SIZE_B:  load_value = {{56{!r_load_unsigned && lane[7]}},  lane[7:0]};
            SIZE_H:  load_value = {{48{!r_load_unsigned && lane[15]}}, lane[15:0]};
            SIZE_W:  load_value = {{32{!r_load_unsigned && lane[31]}}, lane[31:0]};
            default: load_value = lane;
        endcase
    end

    // Writeback record
    assign wb_valid = ms_valid;
    assign wb_rd    = r_rd;
    assign wb_rf_we = r_rf_we;
    assign wb_data  = r_mem_re ? load_value : r_result;
    assign wb_pc    = r_pc;

    // Stalled writeback keeps its record and load data
    assert property (@(posedge clk) disable iff (reset)
        wb_valid && !wb_allowin |=> wb_valid && $stable(wb_data) && $stable(wb_rd));

endmodule

// ==== verilog/exec_pipe.sv ====
// Execute and memory pipeline top
`timescale 1ns/1ps

module exec_pipe #(
    parameter int DMEM_DEPTH = exec_pkg::DMEM_DEPTH_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    // Decoded micro-op in
    input  logic                 in_valid,
    output logic                 in_allowin,
    input  exec_pkg::alu_op_t    in_op,
    input  logic                 in_word,
    input  exec_pkg::src1_sel_t  in_src1_sel,
    input  exec_pkg::src2_sel_t  in_src2_sel,
    input  exec_pkg::xlen_t      in_rs1_value,
    input  exec_pkg::xlen_t      in_rs2_value,
    input  exec_pkg::xlen_t      in_imm,
    input  exec_pkg::pc_t        in_pc,
    input  exec_pkg::reg_idx_t   in_rd,
    input  logic                 in_rf_we,
    input  logic                 in_mem_re,
    input  logic                 in_mem_we,
    input  exec_pkg::mem_size_t  in_mem_size,
    input  logic                 in_load_unsigned,
    // Writeback out
    input  logic                 wb_allowin,
    output logic                 wb_valid,
    output exec_pkg::reg_idx_t   wb_rd,
    output logic                 wb_rf_we,
    output exec_pkg::xlen_t      wb_data,
    output exec_pkg::pc_t        wb_pc,
    // Execute stage forwarding
    output logic                 fwd_valid,
    output logic                 fwd_load,
    output exec_pkg::reg_idx_t   fwd_rd,
    output exec_pkg::xlen_t      fwd_data
);

    es_to_ms_if es_to_ms ();
    dmem_if #(.DEPTH(DMEM_DEPTH)) dmem ();

    exu_stage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) exu_stage_inst (
        .clk              (clk),
        .reset            (reset),
        .in_valid         (in_valid),
        .in_allowin       (in_allowin),
        .in_op            (in_op),
        .in_word          (in_word),
        .in_src1_sel      (in_src1_sel),
        .in_src2_sel      (in_src2_sel),
        .in_rs1_value     (in_rs1_value),
        .in_rs2_value     (in_rs2_value),
        .in_imm           (in_imm),
        .in_pc            (in_pc),
        .in_rd            (in_rd),
        .in_rf_we         (in_rf_we),
        .in_mem_re        (in_mem_re),
        .in_mem_we        (in_mem_we),
        .in_mem_size      (in_mem_size),
        .in_load_unsigned (in_load_unsigned),
        .out              (es_to_ms.master),
        .dmem             (dmem.master),
        .fwd_valid        (fwd_valid),
        .fwd_load         (fwd_load),
        .fwd_rd           (fwd_rd),
        .fwd_data         (fwd_data)
    );

    data_ram #(
        .DEPTH (DMEM_DEPTH)
    ) data_ram_inst (
        .clk (clk),
        .bus (dmem.slave)
    );

    mem_stage mem_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .in         (es_to_ms.slave),
        .dmem       (dmem.resp),
        .wb_allowin (wb_allowin),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_rf_we   (wb_rf_we),
        .wb_data    (wb_data),
        .wb_pc      (wb_pc)
    );

endmodule

// ==== testbench/tb_exec_pipe.sv ====
// Execute pipeline testbench
`timescale 1ns/1ps

module tb_exec_pipe;
    import exec_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 5;
    localparam int ISSUE_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 50;

    typedef struct packed {
        reg_idx_t rd;
        logic     rf_we;
        logic     is_load;
        pc_t      pc;
        xlen_t    alu;
        xlen_t    data;
    } wb_rec_t;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      in_allowin;
    alu_op_t   in_op;
    logic      in_word;
    src1_sel_t in_src1_sel;
    src2_sel_t in_src2_sel;
    xlen_t     in_rs1_value;
    xlen_t     in_rs2_value;
    xlen_t     in_imm;
    pc_t       in_pc;
    reg_idx_t  in_rd;
    logic      in_rf_we;
    logic      in_mem_re;
    logic      in_mem_we;
    mem_size_t in_mem_size;
    logic      in_load_unsigned;
    logic      wb_allowin;
    logic      wb_valid;
    reg_idx_t  wb_rd;
    logic      wb_rf_we;
    xlen_t     wb_data;
    pc_t       wb_pc;
    logic      fwd_valid;
    logic      fwd_load;
    reg_idx_t  fwd_rd;
    xlen_t     fwd_data;

    // Reference state
    wb_rec_t exp_q[$];
    wb_rec_t pending;
    xlen_t   shadow [DMEM_DEPTH_DEFAULT];
    pc_t     next_pc = 64'h8000_0000;
    integer  seed = 20;
    logic    accepted;
    logic    stall_mode = 1'b0;
    logic    hold_wb = 1'b0;
    int      fwd_checks = 0;
    int      fwd_load_checks = 0;

    exec_pipe #(
        .DMEM_DEPTH (DMEM_DEPTH_DEFAULT)
    ) exec_pipe_inst (
        .clk              (clk),
        .reset            (reset),
        .in_valid         (in_valid),
        .in_allowin       (in_allowin),
        .in_op            (in_op),
        .in_word          (in_word),
        .in_src1_sel      (in_src1_sel),
        .in_src2_sel      (in_src2_sel),
        .in_rs1_value     (in_rs1_value),
        .in_rs2_value     (in_rs2_value),
        .in_imm           (in_imm),
        .in_pc            (in_pc),
        .in_rd            (in_rd),
        .in_rf_we         (in_rf_we),
        .in_mem_re        (in_mem_re),
        .in_mem_we        (in_mem_we),
        .in_mem_size      (in_mem_size),
        .in_load_unsigned (in_load_unsigned),
        .wb_allowin       (wb_allowin),
        .wb_valid         (wb_valid),
        .wb_rd            (wb_rd),
        .wb_rf_we         (wb_rf_we),
        .wb_data          (wb_data),
        .wb_pc            (wb_pc),
        .fwd_valid        (fwd_valid),
        .fwd_load         (fwd_load),
        .fwd_rd           (fwd_rd),
        .fwd_data         (fwd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // Failure reporting and compares
    // ------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_data(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %0d ns: %s is %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_rd(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %0d ns: %s is %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %0d ns: %s is %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %0d ns: %s is %b, expected %b",
                                     $time, what, got, exp));
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic xlen_t model_alu(input alu_op_t op, input logic word,
                                        input xlen_t a, input xlen_t b);
        xlen_t r;
        xlen_t lo_zext;
        xlen_t lo_sext;
        int    sh;
        sh      = word ? int'(b[4:0]) : int'(b[5:0]);
        lo_zext = {32'b0, a[31:0]};
        lo_sext = {{32{a[31]}}, a[31:0]};
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            OP_SLTU: r = (a < b) ? 64'd1 : 64'd0;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << sh;
            OP_SRL:  r = word ? lo_zext >> sh : a >> sh;
            OP_SRA:  r = word ? xlen_t'($signed(lo_sext) >>> sh) : xlen_t'($signed(a) >>> sh);
            default: r = 'x;
        endcase
        if (word) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        return r;
    endfunction

    function automatic void store_shadow(input xlen_t addr, input xlen_t value,
                                         input mem_size_t size);
        int idx;
        int off;
        idx = int'(addr[11:3]);
        off = int'(addr[2:0]);
        for (int i = 0; i < (1 << size); i++) begin
            shadow[idx][(off + i) * 8 +: 8] = value[i * 8 +: 8];
        end
    endfunction

    function automatic xlen_t load_shadow(input xlen_t addr, input mem_size_t size,
                                          input logic uns);
        xlen_t value;
        int    idx;
        int    off;
        int    nbytes;
        idx    = int'(addr[11:3]);
        off    = int'(addr[2:0]);
        nbytes = 1 << size;
        value  = '0;
        for (int i = 0; i < nbytes; i++) begin
            value[i * 8 +: 8] = shadow[idx][(off + i) * 8 +: 8];
        end
        // Sign fill above the loaded bytes
        if (!uns && nbytes < 8 && value[nbytes * 8 - 1]) begin
            value = value | (~xlen_t'(0) << (nbytes * 8));
        end
        return value;
    endfunction

    function automatic xlen_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic reg_idx_t rand_rd();
        return reg_idx_t'($random(seed));
    endfunction

    // ------------------------------
    // Cycle step and monitor
    // ------------------------------
    // Samples just before the rising edge, when everything has settled
    task automatic monitor();
        wb_rec_t rec;
        accepted = in_valid && in_allowin;
        if (fwd_valid || fwd_load) begin
            if (exp_q.size() == 0) begin
                report_failure("Forwarding record seen with an empty pipeline");
            end else begin
                rec = exp_q[$];
                check_flag(fwd_valid, rec.rf_we, "fwd_valid");
                check_flag(fwd_load, rec.is_load, "fwd_load");
                check_rd(fwd_rd, rec.rd, "fwd_rd");
                check_data(fwd_data, rec.alu, "fwd_data");
                fwd_checks++;
                if (rec.is_load) begin
                    fwd_load_checks++;
                end
            end
        end
        if (wb_valid && wb_allowin) begin
            if (exp_q.size() == 0) begin
                report_failure("Writeback retired a micro-op that was never issued");
            end else begin
                rec = exp_q.pop_front();
                check_rd(wb_rd, rec.rd, "wb_rd");
                check_flag(wb_rf_we, rec.rf_we, "wb_rf_we");
                check_pc(wb_pc, rec.pc, "wb_pc");
                check_data(wb_data, rec.data, "wb_data");
            end
        end
        if (accepted) begin
            exp_q.push_back(pending);
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic tick();
        if (hold_wb) begin
            wb_allowin = 1'b0;
        end else if (stall_mode) begin
            wb_allowin = (($random(seed) & 3) != 0);
        end else begin
            wb_allowin = 1'b1;
        end
        #(CLK_PERIOD / 2 - 1);
        monitor();
        @(negedge clk);
    endtask

    task automatic issue(
        input alu_op_t   op,
        input logic      word,
        input src1_sel_t s1,
        input src2_sel_t s2,
        input xlen_t     rs1,
        input xlen_t     rs2,
        input xlen_t     imm,
        input reg_idx_t  rd,
        input logic      rf_we,
        input logic      re,
        input logic      we,
        input mem_size_t size,
        input logic      uns
    );
        xlen_t a;
        xlen_t b;
        int    waited;
        a = (s1 == SRC1_PC) ? next_pc : (s1 == SRC1_ZERO) ? xlen_t'(0) : rs1;
        b = (s2 == SRC2_IMM) ? imm : (s2 == SRC2_FOUR) ? xlen_t'(4) : rs2;
        pending.rd      = rd;
        pending.rf_we   = rf_we;
        pending.is_load = re;
        pending.pc      = next_pc;
        pending.alu     = model_alu(op, word, a, b);
        pending.data    = pending.alu;
        if (we) begin
            store_shadow(pending.alu, rs2, size);
        end
        if (re) begin
            pending.data = load_shadow(pending.alu, size, uns);
        end
        in_valid         = 1'b1;
        in_op            = op;
        in_word          = word;
        in_src1_sel      = s1;
        in_src2_sel      = s2;
        in_rs1_value     = rs1;
        in_rs2_value     = rs2;
        in_imm           = imm;
        in_pc            = next_pc;
        in_rd            = rd;
        in_rf_we         = rf_we;
        in_mem_re        = re;
        in_mem_we        = we;
        in_mem_size      = size;
        in_load_unsigned = uns;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            if (waited == ISSUE_TIMEOUT) begin
                report_failure("Timeout: the pipeline never accepted a micro-op");
            end else begin
                tick();
                waited++;
            end
        end
        in_valid = 1'b0;
        next_pc  = next_pc + 64'd4;
    endtask

    task automatic alu_op(input alu_op_t op, input logic word, input src1_sel_t s1,
                          input src2_sel_t s2, input xlen_t rs1, input xlen_t rs2,
                          input xlen_t imm);
        issue(op, word, s1, s2, rs1, rs2, imm, rand_rd(), 1'b1, 1'b0, 1'b0, SIZE_D, 1'b0);
    endtask

    task automatic mem_store(input xlen_t addr, input xlen_t value, input mem_size_t size);
        issue(OP_ADD, 1'b0, SRC1_RS1, SRC2_IMM, addr - 64'd16, value, 64'd16,
              5'd0, 1'b0, 1'b0, 1'b1, size, 1'b0);
    endtask

    // Base above the target with a negative offset
    task automatic mem_load(input xlen_t addr, input mem_size_t size, input logic uns);
        issue(OP_ADD, 1'b0, SRC1_RS1, SRC2_IMM, addr + 64'd8, rand_word(), xlen_t'(-8),
              rand_rd(), 1'b1, 1'b1, 1'b0, size, uns);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == DRAIN_TIMEOUT) begin
                report_failure("Timeout: the pipeline did not drain");
            end else begin
                tick();
                waited++;
            end
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_reset();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_flag(wb_valid, 1'b0, "wb_valid in reset");
            check_flag(fwd_valid, 1'b0, "fwd_valid in reset");
            check_flag(in_allowin, 1'b1, "in_allowin in reset");
        end
        reset = 1'b0;
        tick();
        tick();
        check_flag(wb_valid, 1'b0, "wb_valid after reset");
        check_flag(fwd_valid, 1'b0, "fwd_valid after reset");
        check_flag(in_allowin, 1'b1, "in_allowin after reset");
    endtask

    task automatic test_alu();
        for (int w = 0; w < 2; w++) begin
            for (int i = 0; i < 10; i++) begin
                alu_op(alu_op_t'(i), w == 1, SRC1_RS1, SRC2_RS2, rand_word(), rand_word(), '0);
                alu_op(alu_op_t'(i), w == 1, SRC1_RS1, SRC2_IMM, rand_word(), '0,
                       xlen_t'($signed($random(seed)) >>> 20));
            end
        end
        // Link address, lui and auipc
        alu_op(OP_ADD, 1'b0, SRC1_PC, SRC2_FOUR, rand_word(), rand_word(), rand_word());
        alu_op(OP_ADD, 1'b0, SRC1_ZERO, SRC2_IMM, rand_word(), '0, 64'hffff_ffff_8765_4000);
        alu_op(OP_ADD, 1'b1, SRC1_PC, SRC2_IMM, '0, '0, 64'h0000_0000_7fff_f000);
        drain();
    endtask

    task automatic test_mem();
        for (int s = 0; s < 4; s++) begin
            mem_store(64'h100 + xlen_t'(s * 8), rand_word(), SIZE_D);
        end
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off += (1 << s)) begin
                mem_store(64'h100 + xlen_t'(s * 8 + off), rand_word(), mem_size_t'(s));
            end
        end
        for (int w = 0; w < 4; w++) begin
            for (int s = 0; s < 4; s++) begin
                for (int off = 0; off < 8; off += (1 << s)) begin
                    mem_load(64'h100 + xlen_t'(w * 8 + off), mem_size_t'(s), 1'b0);
                    mem_load(64'h100 + xlen_t'(w * 8 + off), mem_size_t'(s), 1'b1);
                end
            end
        end
        drain();
    endtask

    task automatic test_backpressure();
        int kind;
        for (int i = 0; i < 8; i++) begin
            mem_store(64'h200 + xlen_t'(i * 8), rand_word(), SIZE_D);
        end
        stall_mode = 1'b1;
        for (int i = 0; i < 60; i++) begin
            kind = $random(seed) & 3;
            if (kind == 0) begin
                mem_store(64'h200 + xlen_t'((i & 7) * 8), rand_word(), mem_size_t'(i & 3));
            end else if (kind == 1) begin
                mem_load(64'h200 + xlen_t'(((i + 3) & 7) * 8), mem_size_t'(i & 3), i[2]);
            end else begin
                alu_op(alu_op_t'(i % 10), i[0], SRC1_RS1, SRC2_RS2, rand_word(), rand_word(), '0);
            end
        end
        drain();
        // Store parked in execute behind a full memory stage
        stall_mode = 1'b0;
        hold_wb    = 1'b1;
        alu_op(OP_XOR, 1'b0, SRC1_RS1, SRC2_RS2, rand_word(), rand_word(), '0);
        mem_store(64'h240, rand_word(), SIZE_D);
        for (int i = 0; i < 6; i++) begin
            tick();
        end
        check_flag(in_allowin, 1'b0, "in_allowin with both stages full");
        hold_wb = 1'b0;
        drain();
        mem_store(64'h243, rand_word(), SIZE_B);
        mem_load(64'h240, SIZE_D, 1'b0);
        mem_load(64'h243, SIZE_B, 1'b1);
        drain();
    endtask

    task automatic test_forwarding();
        for (int i = 0; i < 24; i++) begin
            case (i % 4)
                0: alu_op(alu_op_t'($unsigned($random(seed)) % 10), 1'b0, SRC1_RS1, SRC2_IMM,
                          rand_word(), '0, xlen_t'($signed($random(seed)) >>> 16));
                1: mem_load(64'h100 + xlen_t'((i & 3) * 8), SIZE_W, i[3]);
                2: mem_store(64'h108, rand_word(), SIZE_H);
                default: alu_op(OP_SUB, 1'b1, SRC1_RS1, SRC2_RS2, rand_word(), rand_word(), '0);
            endcase
        end
        drain();
        if (fwd_checks == 0 || fwd_load_checks == 0) begin
            report_failure("Forwarding record was never observed for ALU ops and loads");
        end
    endtask

    initial begin
        reset            = 1'b1;
        in_valid         = 1'b0;
        in_op            = OP_ADD;
        in_word          = 1'b0;
        in_src1_sel      = SRC1_RS1;
        in_src2_sel      = SRC2_RS2;
        in_rs1_value     = '0;
        in_rs2_value     = '0;
        in_imm           = '0;
        in_pc            = '0;
        in_rd            = '0;
        in_rf_we         = 1'b0;
        in_mem_re        = 1'b0;
        in_mem_we        = 1'b0;
        in_mem_size      = SIZE_B;
        in_load_unsigned = 1'b0;
        wb_allowin       = 1'b1;
        pending          = '0;

        test_reset();
        test_alu();
        test_mem();
        test_backpressure();
        test_forwarding();

        // All expected records retired, so no stage may still be valid
        if (!wb_valid && !fwd_valid && !fwd_load) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            report_failure("Pipeline still holds a micro-op after every one has retired");
        end
    end

endmodule

// ==== filelist.f ====
verilog/exec_pkg.sv
verilog/pipe_if.sv
verilog/alu.sv
verilog/exu_stage.sv
verilog/data_ram.sv
verilog/mem_stage.sv
verilog/exec_pipe.sv
testbench/tb_exec_pipe.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_exec_pipe \
    -Mdir obj_dir -o tb_exec_pipe > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_exec_pipe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
